// File: verilog/cachePkg.sv
// ****************************************
// cache package
// widths, line types and MSI encodings
// ****************************************
`default_nettype none

package cachePkg;

    localparam int ADDR_WIDTH = 16;
    localparam int WORD_WIDTH = 32;

    // processor hold-off after a snoop write-back
    localparam int HOLDOFF_CYCLES = 4;
    localparam int HOLDOFF_WIDTH = 3;

    typedef logic [ADDR_WIDTH-1:0] addrT;
    typedef logic [WORD_WIDTH-1:0] wordT;
    typedef logic [HOLDOFF_WIDTH-1:0] holdoffT;

    // stable coherence states of the line
    typedef enum logic [1:0] {
        modified = 2'd0,
        shared = 2'd1,
        invalid = 2'd2
    } coherT;

    // snoop bus messages, same encoding both ways
    typedef enum logic [1:0] {
        none = 2'd0,
        readMiss = 2'd1,
        writeMiss = 2'd2,
        invalidate = 2'd3
    } busOpT;

endpackage

`default_nettype wire

// File: verilog/lineStore.sv
// ****************************************
// line store
// tag, data word and MSI state, with hit compares
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module lineStore (
    input  logic              clk,
    input  logic              reset,
    input  logic              loadLine,
    input  logic              writeLine,
    input  logic              setState,
    input  cachePkg::addrT    newAddr,
    input  cachePkg::wordT    newData,
    input  cachePkg::coherT   nextCoher,
    input  cachePkg::addrT    cpuAddr,
    input  cachePkg::addrT    snoopAddr,
    output cachePkg::coherT   lineState,
    output cachePkg::addrT    lineTag,
    output cachePkg::wordT    lineData,
    output logic              cpuHit,
    output logic              snoopHit
);

    import cachePkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            lineState <= invalid;
        end else if (setState) begin
            lineState <= nextCoher;
        end
    end

    // a fill replaces tag and word, a write only the word
    always_ff @(posedge clk) begin
        if (loadLine) begin
            lineTag <= newAddr;
            lineData <= newData;
        end else if (writeLine) begin
            lineData <= newData;
        end
    end

    // invalid never hits
    assign cpuHit = (lineState != invalid) && (lineTag == cpuAddr);
    assign snoopHit = (lineState != invalid) && (lineTag == snoopAddr);

endmodule

`default_nettype wire

// File: verilog/memRequest.sv
// ****************************************
// memory request
// holds one request through valid/ready
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module memRequest (
    input  logic              clk,
    input  logic              reset,
    input  logic              memIssue,
    input  logic              memIssueWrite,
    input  cachePkg::addrT    memIssueAddr,
    input  cachePkg::wordT    memIssueData,
    output logic              memReqValid,
    output logic              memWrite,
    output cachePkg::addrT    memAddr,
    output cachePkg::wordT    memWdata,
    input  logic              memReqReady,
    input  logic              memRespValid,
    input  cachePkg::wordT    memRdata,
    output logic              memDone,
    output cachePkg::wordT    memFill
);

    logic pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            memReqValid <= 1'b0;
            pending <= 1'b0;
        end else begin
            if (memIssue) begin
                memReqValid <= 1'b1;
                pending <= 1'b1;
            end else if (memReqValid && memReqReady) begin
                memReqValid <= 1'b0;
            end
            // pending lasts past the handshake until the response
            if (memDone) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (memIssue) begin
            memWrite <= memIssueWrite;
            memAddr <= memIssueAddr;
            memWdata <= memIssueData;
        end
    end

    assign memDone = memRespValid && pending;
    assign memFill = memRdata;

    respExpected: assert property (@(posedge clk) disable iff (reset)
        memRespValid |-> pending)
        else $error("memory response with nothing outstanding");

endmodule

`default_nettype wire

// File: verilog/backoffTimer.sv
// ****************************************
// backoff timer
// hold-off window after a snoop write-back
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module backoffTimer (
    input  logic clk,
    input  logic reset,
    input  logic holdStart,
    output logic holdBusy
);

    import cachePkg::*;

    holdoffT count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (holdStart) begin
            count <= holdoffT'(HOLDOFF_CYCLES);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign holdBusy = (count != '0);

    noRestart: assert property (@(posedge clk) disable iff (reset)
        holdStart |-> !holdBusy)
        else $error("hold-off restarted while busy");

endmodule

`default_nettype wire

// File: verilog/coherenceFsm.sv
// ****************************************
// coherence FSM
// sequences hits, misses, write-backs and snoops
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module coherenceFsm (
    input  logic              clk,
    input  logic              reset,
    input  logic              cpuValid,
    input  logic              cpuWrite,
    input  cachePkg::addrT    cpuAddr,
    input  cachePkg::wordT    cpuWdata,
    output logic              cpuReady,
    output logic              cpuRespValid,
    output cachePkg::wordT    cpuRdata,
    input  logic              snoopValid,
    input  cachePkg::busOpT   snoopOp,
    input  cachePkg::addrT    snoopAddr,
    output logic              snoopReady,
    output logic              busValid,
    output cachePkg::busOpT   busOp,
    output cachePkg::addrT    busAddr,
    input  logic              busReady,
    input  logic              cpuHit,
    input  logic              snoopHit,
    input  cachePkg::coherT   lineState,
    input  cachePkg::wordT    lineData,
    input  cachePkg::addrT    lineTag,
    output logic              loadLine,
    output logic              writeLine,
    output logic              setState,
    output cachePkg::coherT   nextCoher,
    output logic              memIssue,
    output logic              memIssueWrite,
    output cachePkg::addrT    memIssueAddr,
    output cachePkg::wordT    memIssueData,
    input  logic              memDone,
    input  cachePkg::wordT    memFill,
    output logic              holdStart,
    input  logic              holdBusy
);

    import cachePkg::*;

    typedef enum logic [3:0] {
        idle,
        evictWb,
        missCast,
        fillWait,
        mergeWrite,
        invCast,
        snoopWb,
        holdGap,
        settle
    } fsmT;

    fsmT state;
    logic reqWrite;
    addrT reqAddr;
    wordT reqData;
    coherT snoopTarget;
    logic cpuTake;
    logic snoopTake;

    // snoops win over the processor
    assign snoopReady = (state == idle);
    assign cpuReady = (state == idle) && !snoopValid && !holdBusy;
    assign cpuTake = cpuValid && cpuReady;
    assign snoopTake = snoopValid && snoopReady;

    always_ff @(posedge clk) begin
        cpuRespValid <= 1'b0;
        loadLine <= 1'b0;
        writeLine <= 1'b0;
        setState <= 1'b0;
        memIssue <= 1'b0;
        holdStart <= 1'b0;
        if (reset) begin
            state <= idle;
            busValid <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (snoopTake) begin
                        if (snoopHit && lineState == modified &&
                                (snoopOp == readMiss || snoopOp == writeMiss)) begin
                            memIssue <= 1'b1;
                            memIssueWrite <= 1'b1;
                            memIssueAddr <= snoopAddr;
                            memIssueData <= lineData;
                            snoopTarget <= (snoopOp == readMiss) ? shared : invalid;
                            state <= snoopWb;
                        end else if (snoopHit && lineState == shared &&
                                (snoopOp == writeMiss || snoopOp == invalidate)) begin
                            setState <= 1'b1;
                            nextCoher <= invalid;
                            state <= settle;
                        end
                    end else if (cpuTake) begin
                        reqWrite <= cpuWrite;
                        reqAddr <= cpuAddr;
                        reqData <= cpuWdata;
                        if (cpuHit && !cpuWrite) begin
                            cpuRespValid <= 1'b1;
                            cpuRdata <= lineData;
                        end else if (cpuHit && lineState == modified) begin
                            writeLine <= 1'b1;
                            memIssueData <= cpuWdata;
                            cpuRespValid <= 1'b1;
                            state <= settle;
                        end else if (cpuHit) begin
                            // shared write hit needs the others invalidated
                            busValid <= 1'b1;
                            busOp <= invalidate;
                            busAddr <= cpuAddr;
                            state <= invCast;
                        end else if (lineState == modified) begin
                            memIssue <= 1'b1;
                            memIssueWrite <= 1'b1;
                            memIssueAddr <= lineTag;
                            memIssueData <= lineData;
                            state <= evictWb;
                        end else begin
                            busValid <= 1'b1;
                            busOp <= cpuWrite ? writeMiss : readMiss;
                            busAddr <= cpuAddr;
                            state <= missCast;
                        end
                    end
                end
                evictWb: begin
                    if (memDone) begin
                        busValid <= 1'b1;
                        busOp <= reqWrite ? writeMiss : readMiss;
                        busAddr <= reqAddr;
                        state <= missCast;
                    end
                end
                missCast: begin
                    if (busReady) begin
                        busValid <= 1'b0;
                        memIssue <= 1'b1;
                        memIssueWrite <= 1'b0;
                        memIssueAddr <= reqAddr;
                        state <= fillWait;
                    end
                end
                fillWait: begin
                    if (memDone) begin
                        // issue address doubles as the fill tag
                        memIssueData <= memFill;
                        loadLine <= 1'b1;
                        setState <= 1'b1;
                        nextCoher <= reqWrite ? modified : shared;
                        if (reqWrite) begin
                            state <= mergeWrite;
                        end else begin
                            cpuRespValid <= 1'b1;
                            cpuRdata <= memFill;
                            state <= settle;
                        end
                    end
                end
                mergeWrite: begin
                    writeLine <= 1'b1;
                    memIssueData <= reqData;
                    cpuRespValid <= 1'b1;
                    state <= settle;
                end
                invCast: begin
                    if (busReady) begin
                        busValid <= 1'b0;
                        writeLine <= 1'b1;
                        memIssueData <= reqData;
                        setState <= 1'b1;
                        nextCoher <= modified;
                        cpuRespValid <= 1'b1;
                        state <= settle;
                    end
                end
                snoopWb: begin
                    if (memDone) begin
                        setState <= 1'b1;
                        nextCoher <= snoopTarget;
                        holdStart <= 1'b1;
                        state <= holdGap;
                    end
                end
                // lets the timer go busy before ready returns
                holdGap: state <= idle;
                // line store takes its update here
                settle: state <= idle;
                default: state <= idle;
            endcase
        end
    end

    respSingle: assert property (@(posedge clk) disable iff (reset)
        cpuRespValid |=> !cpuRespValid)
        else $error("cpu response held for two cycles");

    issueOnce: assert property (@(posedge clk) disable iff (reset)
        memIssue |=> (!memIssue until memDone))
        else $error("memory issue while a request is outstanding");

endmodule

`default_nettype wire

// File: verilog/snoopCache.sv
// ****************************************
// snooping cache controller
// one MSI line between processor, memory and bus
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module snoopCache (
    input  logic              clk,
    input  logic              reset,
    input  logic              cpuValid,
    input  logic              cpuWrite,
    input  cachePkg::addrT    cpuAddr,
    input  cachePkg::wordT    cpuWdata,
    output logic              cpuReady,
    output logic              cpuRespValid,
    output cachePkg::wordT    cpuRdata,
    output logic              memReqValid,
    output logic              memWrite,
    output cachePkg::addrT    memAddr,
    output cachePkg::wordT    memWdata,
    input  logic              memReqReady,
    input  logic              memRespValid,
    input  cachePkg::wordT    memRdata,
    input  logic              snoopValid,
    input  cachePkg::busOpT   snoopOp,
    input  cachePkg::addrT    snoopAddr,
    output logic              snoopReady,
    output logic              busValid,
    output cachePkg::busOpT   busOp,
    output cachePkg::addrT    busAddr,
    input  logic              busReady
);

    import cachePkg::*;

    logic cpuHit;
    logic snoopHit;
    coherT lineState;
    wordT lineData;
    addrT lineTag;
    logic loadLine;
    logic writeLine;
    logic setState;
    coherT nextCoher;
    logic memIssue;
    logic memIssueWrite;
    addrT memIssueAddr;
    wordT memIssueData;
    logic memDone;
    wordT memFill;
    logic holdStart;
    logic holdBusy;

    coherenceFsm fsm (
        .clk(clk),
        .reset(reset),
        .cpuValid(cpuValid),
        .cpuWrite(cpuWrite),
        .cpuAddr(cpuAddr),
        .cpuWdata(cpuWdata),
        .cpuReady(cpuReady),
        .cpuRespValid(cpuRespValid),
        .cpuRdata(cpuRdata),
        .snoopValid(snoopValid),
        .snoopOp(snoopOp),
        .snoopAddr(snoopAddr),
        .snoopReady(snoopReady),
        .busValid(busValid),
        .busOp(busOp),
        .busAddr(busAddr),
        .busReady(busReady),
        .cpuHit(cpuHit),
        .snoopHit(snoopHit),
        .lineState(lineState),
        .lineData(lineData),
        .lineTag(lineTag),
        .loadLine(loadLine),
        .writeLine(writeLine),
        .setState(setState),
        .nextCoher(nextCoher),
        .memIssue(memIssue),
        .memIssueWrite(memIssueWrite),
        .memIssueAddr(memIssueAddr),
        .memIssueData(memIssueData),
        .memDone(memDone),
        .memFill(memFill),
        .holdStart(holdStart),
        .holdBusy(holdBusy)
    );

    // line updates ride on the issue address and data registers
    lineStore store (
        .clk(clk),
        .reset(reset),
        .loadLine(loadLine),
        .writeLine(writeLine),
        .setState(setState),
        .newAddr(memIssueAddr),
        .newData(memIssueData),
        .nextCoher(nextCoher),
        .cpuAddr(cpuAddr),
        .snoopAddr(snoopAddr),
        .lineState(lineState),
        .lineTag(lineTag),
        .lineData(lineData),
        .cpuHit(cpuHit),
        .snoopHit(snoopHit)
    );

    memRequest request (
        .clk(clk),
        .reset(reset),
        .memIssue(memIssue),
        .memIssueWrite(memIssueWrite),
        .memIssueAddr(memIssueAddr),
        .memIssueData(memIssueData),
        .memReqValid(memReqValid),
        .memWrite(memWrite),
        .memAddr(memAddr),
        .memWdata(memWdata),
        .memReqReady(memReqReady),
        .memRespValid(memRespValid),
        .memRdata(memRdata),
        .memDone(memDone),
        .memFill(memFill)
    );

    backoffTimer timer (
        .clk(clk),
        .reset(reset),
        .holdStart(holdStart),
        .holdBusy(holdBusy)
    );

endmodule

`default_nettype wire

// File: sim/memModel.sv
// ****************************************
// memory model
// answers one request at a time after a drawn delay
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module memModel (
    input  logic              clk,
    input  logic              reset,
    input  logic [2:0]        delay,
    input  logic              reqValid,
    input  logic              write,
    input  cachePkg::addrT    addr,
    input  cachePkg::wordT    wdata,
    output logic              reqReady,
    output logic              respValid,
    output cachePkg::wordT    rdata
);

    import cachePkg::*;

    wordT mem [addrT];
    logic busy = 1'b0;
    logic pulse = 1'b0;
    wordT readWord = '0;
    logic [2:0] remaining = '0;
    logic takeWrite = 1'b0;
    addrT takeAddr = '0;
    wordT takeData = '0;

    // unwritten words follow a pattern of the full address
    function automatic wordT initialWord(input addrT a);
        return {~a, a} ^ 32'h6b1d_e327;
    endfunction

    assign reqReady = !busy && !reset;
    assign respValid = pulse;
    assign rdata = readWord;

    always @(posedge clk) begin
        pulse <= 1'b0;
        if (reset) begin
            busy <= 1'b0;
        end else if (!busy) begin
            if (reqValid) begin
                busy <= 1'b1;
                remaining <= delay;
                takeWrite <= write;
                takeAddr <= addr;
                takeData <= wdata;
            end
        end else if (remaining != '0) begin
            remaining <= remaining - 3'd1;
        end else begin
            busy <= 1'b0;
            pulse <= 1'b1;
            if (takeWrite) begin
                mem[takeAddr] = takeData;
            end else begin
                readWord <= mem.exists(takeAddr) ? mem[takeAddr] : initialWord(takeAddr);
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/snoopCacheTb.sv
// ****************************************
// snooping cache testbench
// processor and snoop traffic against a shadow model
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module snoopCacheTb;

    import cachePkg::*;

    localparam int waitLimit = 200;
    localparam logic [1:0] kindRead = 2'd1;
    localparam logic [1:0] kindWrite = 2'd2;
    localparam logic [1:0] kindCast = 2'd3;

    typedef struct packed {
        logic [1:0] kind;
        addrT addr;
        wordT data;
    } eventT;

    logic clk;
    logic reset;
    logic cpuValid;
    logic cpuWrite;
    addrT cpuAddr;
    wordT cpuWdata;
    logic cpuReady;
    logic cpuRespValid;
    wordT cpuRdata;
    logic memReqValid;
    logic memWrite;
    addrT memAddr;
    wordT memWdata;
    logic memReqReady;
    logic memRespValid;
    wordT memRdata;
    logic snoopValid;
    busOpT snoopOp;
    addrT snoopAddr;
    logic snoopReady;
    logic busValid;
    busOpT busOp;
    addrT busAddr;
    logic busReady = 1'b1;

    logic [31:0] lfsr = 32'h14f;
    logic [2:0] memDelay = 3'd0;
    wordT randWord = '0;

    // shadow of memory and of the line
    wordT shadow [addrT];
    coherT expState;
    addrT expTag;
    wordT expData;
    eventT seen[$];
    eventT expected[$];

    snoopCache i_dut (
        .clk(clk), .reset(reset),
        .cpuValid(cpuValid), .cpuWrite(cpuWrite), .cpuAddr(cpuAddr), .cpuWdata(cpuWdata),
        .cpuReady(cpuReady), .cpuRespValid(cpuRespValid), .cpuRdata(cpuRdata),
        .memReqValid(memReqValid), .memWrite(memWrite), .memAddr(memAddr),
        .memWdata(memWdata), .memReqReady(memReqReady), .memRespValid(memRespValid),
        .memRdata(memRdata),
        .snoopValid(snoopValid), .snoopOp(snoopOp), .snoopAddr(snoopAddr),
        .snoopReady(snoopReady),
        .busValid(busValid), .busOp(busOp), .busAddr(busAddr), .busReady(busReady)
    );

    memModel memory (
        .clk(clk), .reset(reset), .delay(memDelay),
        .reqValid(memReqValid), .write(memWrite), .addr(memAddr), .wdata(memWdata),
        .reqReady(memReqReady), .respValid(memRespValid), .rdata(memRdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // bus stalls, memory delay and data, one bit per step
    always @(posedge clk) begin : randomDraw
        logic [31:0] s;
        logic [36:0] bits;
        s = lfsr;
        for (int i = 0; i < 37; i++) begin
            s = lfsrStep(s);
            bits[i] = s[0];
        end
        lfsr <= s;
        busReady <= bits[0] | bits[1];
        memDelay <= bits[4:2];
        randWord <= bits[36:5];
    end

    function automatic eventT makeEvent(input logic [1:0] kind, input addrT a, input wordT d);
        eventT e;
        e.kind = kind;
        e.addr = a;
        e.data = d;
        return e;
    endfunction

    function automatic wordT shadowRead(input addrT a);
        return shadow.exists(a) ? shadow[a] : ({~a, a} ^ 32'h6b1d_e327);
    endfunction

    // handshakes seen on the memory port and the bus
    always @(negedge clk) begin
        if (!reset && memReqValid && memReqReady) begin
            seen.push_back(makeEvent(memWrite ? kindWrite : kindRead, memAddr,
                memWrite ? memWdata : 32'h0));
        end
        if (!reset && busValid && busReady) begin
            seen.push_back(makeEvent(kindCast, busAddr, wordT'(busOp)));
        end
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic checkEqual(input string name, input logic [63:0] got,
            input logic [63:0] want);
        assert (got === want) else begin
            failRun($sformatf("MISMATCH at %0t: %s = %0h, expected %0h",
                $time, name, got, want));
        end
    endtask

    task automatic compareEvents(input string what);
        checkEqual({what, " event count"}, seen.size(), expected.size());
        foreach (expected[i]) begin
            checkEqual($sformatf("%s event %0d kind", what, i), seen[i].kind, expected[i].kind);
            checkEqual($sformatf("%s event %0d addr", what, i), seen[i].addr, expected[i].addr);
            checkEqual($sformatf("%s event %0d data", what, i), seen[i].data, expected[i].data);
        end
        seen.delete();
        expected.delete();
    endtask

    task automatic cpuAccess(input logic write, input addrT a, input wordT d);
        logic hit;
        logic fast;
        wordT wantRead;
        int waited;
        hit = (expState != invalid) && (expTag == a);
        fast = hit && (!write || expState == modified);
        if (hit && write && expState == shared) begin
            expected.push_back(makeEvent(kindCast, a, wordT'(invalidate)));
        end else if (!hit) begin
            // dirty victim goes out before the miss
            if (expState == modified) begin
                expected.push_back(makeEvent(kindWrite, expTag, expData));
                shadow[expTag] = expData;
            end
            expected.push_back(makeEvent(kindCast, a, wordT'(write ? writeMiss : readMiss)));
            expected.push_back(makeEvent(kindRead, a, 32'h0));
            expTag = a;
            expData = shadowRead(a);
            expState = shared;
        end
        wantRead = expData;
        if (write) begin
            expData = d;
            expState = modified;
        end
        @(posedge clk);
        cpuValid <= 1'b1;
        cpuWrite <= write;
        cpuAddr <= a;
        cpuWdata <= d;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!cpuReady && waited < waitLimit);
        if (!cpuReady) failRun("processor request was never accepted");
        @(posedge clk);
        cpuValid <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!cpuRespValid && waited < waitLimit);
        if (!cpuRespValid) failRun("no processor response before the timeout");
        if (fast) checkEqual("hit latency", waited, 1);
        if (!write) checkEqual("cpuRdata", cpuRdata, wantRead);
        compareEvents(write ? "write" : "read");
    endtask

    task automatic snoopAccess(input busOpT op, input addrT a);
        logic hit;
        logic writeBack;
        int waited;
        int held;
        hit = (expState != invalid) && (expTag == a);
        writeBack = hit && expState == modified && (op == readMiss || op == writeMiss);
        if (writeBack) begin
            expected.push_back(makeEvent(kindWrite, a, expData));
            shadow[a] = expData;
            expState = (op == readMiss) ? shared : invalid;
        end else if (hit && expState == shared && (op == writeMiss || op == invalidate)) begin
            expState = invalid;
        end
        @(posedge clk);
        snoopValid <= 1'b1;
        snoopOp <= op;
        snoopAddr <= a;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!snoopReady && waited < waitLimit);
        if (!snoopReady) failRun("snoop was never accepted");
        @(posedge clk);
        snoopValid <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!snoopReady && waited < waitLimit);
        if (!snoopReady) failRun("snoop handling did not finish");
        if (writeBack) begin
            held = 0;
            while (!cpuReady && held < waitLimit) begin
                held++;
                @(negedge clk);
            end
            checkEqual("cpuReady hold-off cycles", held, HOLDOFF_CYCLES);
        end
        compareEvents("snoop");
    endtask

    initial begin
        wordT r;
        reset = 1'b1;
        cpuValid = 1'b0;
        cpuWrite = 1'b0;
        cpuAddr = '0;
        cpuWdata = '0;
        snoopValid = 1'b0;
        snoopOp = none;
        snoopAddr = '0;
        expState = invalid;
        expTag = '0;
        expData = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkEqual("memReqValid", memReqValid, 0);
        checkEqual("busValid", busValid, 0);
        checkEqual("cpuRespValid", cpuRespValid, 0);
        checkEqual("cpuReady", cpuReady, 1);
        checkEqual("snoopReady", snoopReady, 1);

        cpuAccess(1'b0, 16'h0040, 32'h0);
        cpuAccess(1'b0, 16'h0040, 32'h0);
        cpuAccess(1'b1, 16'h0040, randWord);
        cpuAccess(1'b0, 16'h0040, 32'h0);
        cpuAccess(1'b1, 16'h0040, randWord);
        // evicts the dirty word, then reads it back from memory
        cpuAccess(1'b0, 16'h1234, 32'h0);
        cpuAccess(1'b0, 16'h0040, 32'h0);
        cpuAccess(1'b1, 16'h7777, randWord);
        cpuAccess(1'b1, 16'h0abc, randWord);

        snoopAccess(readMiss, 16'h0001);
        snoopAccess(readMiss, 16'h0abc);
        cpuAccess(1'b0, 16'h0abc, 32'h0);
        cpuAccess(1'b1, 16'h0abc, randWord);
        snoopAccess(writeMiss, 16'h0abc);
        cpuAccess(1'b0, 16'h0abc, 32'h0);
        snoopAccess(invalidate, 16'h0abc);
        cpuAccess(1'b0, 16'h0abc, 32'h0);
        snoopAccess(writeMiss, 16'h0abc);
        cpuAccess(1'b0, 16'h0abc, 32'h0);

        // mixed traffic over a few colliding addresses
        for (int i = 0; i < 60; i++) begin
            r = randWord;
            case (r[1:0])
                2'd0: cpuAccess(1'b0, addrT'({r[7:5], 4'h0}), 32'h0);
                2'd1: cpuAccess(1'b1, addrT'({r[7:5], 4'h0}), r);
                2'd2: snoopAccess(r[4] ? writeMiss : readMiss, addrT'({r[7:5], 4'h0}));
                default: snoopAccess(invalidate, addrT'({r[7:5], 4'h0}));
            endcase
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
verilog/cachePkg.sv
verilog/lineStore.sv
verilog/memRequest.sv
verilog/backoffTimer.sv
verilog/coherenceFsm.sv
verilog/snoopCache.sv
sim/memModel.sv
sim/snoopCacheTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= snoopCacheTb
FILELIST ?= build.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
SOURCES := $(wildcard verilog/*.sv) $(wildcard sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
